// ==== source/versat_pkg.sv ====
package versat_pkg;

   localparam int DATA_W = 32;
   localparam int CFG_ADDR_W = 3;

   // configuration register indices within one stage
   localparam logic [CFG_ADDR_W-1:0] CFG_ALU_OP = 3'd0;
   localparam logic [CFG_ADDR_W-1:0] CFG_SEL_A = 3'd1;
   localparam logic [CFG_ADDR_W-1:0] CFG_SEL_B = 3'd2;
   localparam logic [CFG_ADDR_W-1:0] CFG_MEM_MODE = 3'd3;
   localparam logic [CFG_ADDR_W-1:0] CFG_WR_SEL = 3'd4;
   localparam logic [CFG_ADDR_W-1:0] CFG_START = 3'd5;
   localparam logic [CFG_ADDR_W-1:0] CFG_COUNT = 3'd6;
   localparam logic [CFG_ADDR_W-1:0] CFG_DELAY = 3'd7;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR = 3'd3,
      ALU_XOR = 3'd4,
      ALU_PASS_A = 3'd5
   } alu_op_t;

   typedef enum logic [1:0] {
      SRC_OWN_MEM = 2'd0,
      SRC_OWN_ALU = 2'd1,
      SRC_PREV_MEM = 2'd2,
      SRC_PREV_ALU = 2'd3
   } src_sel_t;

   typedef enum logic {
      MEM_READ = 1'b0,
      MEM_WRITE = 1'b1
   } mem_mode_t;

   typedef enum logic [1:0] {
      AGU_IDLE = 2'd0,
      AGU_WAIT = 2'd1,
      AGU_RUN = 2'd2
   } agu_state_t;

   // one of the four bus words, shared by the alu operands and the write source
   function automatic logic [DATA_W-1:0] pick_src(
      input src_sel_t sel,
      input logic [DATA_W-1:0] own_mem,
      input logic [DATA_W-1:0] own_alu,
      input logic [DATA_W-1:0] prev_mem,
      input logic [DATA_W-1:0] prev_alu
   );
      case (sel)
         SRC_OWN_MEM: return own_mem;
         SRC_OWN_ALU: return own_alu;
         SRC_PREV_MEM: return prev_mem;
         default: return prev_alu;
      endcase
   endfunction

endpackage

// ==== source/stage_agu.sv ====
module stage_agu import versat_pkg::*; #(
   parameter int MEM_ADDR_W = 4
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run,
   input  logic [MEM_ADDR_W-1:0] start,
   input  logic [DATA_W-1:0]     count,
   input  logic [DATA_W-1:0]     delay,
   output logic [MEM_ADDR_W-1:0] agu_addr,
   output logic                  agu_en,
   output logic                  done
);

   agu_state_t        state;
   logic [DATA_W-1:0] wait_cnt;
   logic [DATA_W-1:0] left;

   // wait lasts delay+1 cycles, so the first address lands at T+1+delay
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= AGU_IDLE;
         wait_cnt <= '0;
         left <= '0;
         agu_addr <= '0;
      end else begin
         case (state)
            AGU_IDLE: begin
               if (run) begin
                  state <= AGU_WAIT;
                  wait_cnt <= delay;
                  left <= count;
                  agu_addr <= start;
               end
            end
            AGU_WAIT: begin
               if (wait_cnt == '0)
                  state <= (left == '0) ? AGU_IDLE : AGU_RUN;
               else
                  wait_cnt <= wait_cnt - 1'b1;
            end
            AGU_RUN: begin
               // address wraps with the memory depth
               agu_addr <= agu_addr + 1'b1;
               left <= left - 1'b1;
               if (left == DATA_W'(1))
                  state <= AGU_IDLE;
            end
            default: state <= AGU_IDLE;
         endcase
      end
   end

   assign agu_en = (state == AGU_RUN);
   assign done = (state == AGU_IDLE);

endmodule

// ==== source/stage_mem.sv ====
module stage_mem import versat_pkg::*; #(
   parameter int MEM_ADDR_W = 4
) (
   input  logic                  clk,

   // host side
   input  logic                  host_en,
   input  logic                  host_we,
   input  logic [MEM_ADDR_W-1:0] host_addr,
   input  logic [DATA_W-1:0]     host_wdata,

   // address generator side
   input  logic                  agu_en,
   input  mem_mode_t             mode,
   input  logic [MEM_ADDR_W-1:0] agu_addr,
   input  logic [DATA_W-1:0]     agu_wdata,

   output logic [DATA_W-1:0]     host_rdata,
   output logic [DATA_W-1:0]     flow_rdata
);

   logic [DATA_W-1:0] mem [2**MEM_ADDR_W];

   // one port, agu first
   always_ff @(posedge clk) begin
      if (agu_en) begin
         if (mode == MEM_WRITE)
            mem[agu_addr] <= agu_wdata;
         else
            flow_rdata <= mem[agu_addr];
      end else if (host_en) begin
         if (host_we)
            mem[host_addr] <= host_wdata;
         else
            host_rdata <= mem[host_addr];
      end
   end

endmodule

// ==== source/stage_alu.sv ====
module stage_alu import versat_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  alu_op_t           op,
   input  src_sel_t          sel_a,
   input  src_sel_t          sel_b,
   input  logic [DATA_W-1:0] own_mem,
   input  logic [DATA_W-1:0] own_alu,
   input  logic [DATA_W-1:0] prev_mem,
   input  logic [DATA_W-1:0] prev_alu,
   output logic [DATA_W-1:0] result
);

   logic [DATA_W-1:0] opa;
   logic [DATA_W-1:0] opb;
   logic [DATA_W-1:0] alu_out;

   assign opa = pick_src(sel_a, own_mem, own_alu, prev_mem, prev_alu);
   assign opb = pick_src(sel_b, own_mem, own_alu, prev_mem, prev_alu);

   always_comb begin
      case (op)
         ALU_ADD: alu_out = opa + opb;
         ALU_SUB: alu_out = opa - opb;
         ALU_AND: alu_out = opa & opb;
         ALU_OR: alu_out = opa | opb;
         ALU_XOR: alu_out = opa ^ opb;
         ALU_PASS_A: alu_out = opa;
         // unused op codes give zero
         default: alu_out = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst)
         result <= '0;
      else
         result <= alu_out;
   end

endmodule

// ==== source/versat_stage.sv ====
module versat_stage import versat_pkg::*; #(
   parameter int MEM_ADDR_W = 4
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run,

   // control port
   input  logic                  ctr_valid,
   input  logic                  ctr_we,
   input  logic [CFG_ADDR_W-1:0] ctr_addr,
   input  logic [DATA_W-1:0]     ctr_data_in,
   output logic [DATA_W-1:0]     ctr_data_out,

   // data port
   input  logic                  data_valid,
   input  logic                  data_we,
   input  logic [MEM_ADDR_W-1:0] data_addr,
   input  logic [DATA_W-1:0]     data_data_in,
   output logic [DATA_W-1:0]     data_data_out,

   // stage bus
   input  logic [2*DATA_W-1:0]   flow_in,
   output logic [2*DATA_W-1:0]   flow_out,
   output logic                  done
);

   logic [DATA_W-1:0] cfg [2**CFG_ADDR_W];

   alu_op_t             alu_op;
   src_sel_t            sel_a;
   src_sel_t            sel_b;
   src_sel_t            wr_sel;
   mem_mode_t           mem_mode;
   logic [MEM_ADDR_W-1:0] agu_addr;
   logic                agu_en;
   logic                host_en;
   logic [DATA_W-1:0]   own_mem;
   logic [DATA_W-1:0]   own_alu;
   logic [DATA_W-1:0]   prev_mem;
   logic [DATA_W-1:0]   prev_alu;
   logic [DATA_W-1:0]   wr_word;

   // configuration registers keep the whole word for readback
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int j = 0; j < 2**CFG_ADDR_W; j++)
            cfg[j] <= '0;
      end else if (ctr_valid && ctr_we) begin
         cfg[ctr_addr] <= ctr_data_in;
      end
   end

   assign ctr_data_out = cfg[ctr_addr];

   assign alu_op = alu_op_t'(cfg[CFG_ALU_OP][2:0]);
   assign sel_a = src_sel_t'(cfg[CFG_SEL_A][1:0]);
   assign sel_b = src_sel_t'(cfg[CFG_SEL_B][1:0]);
   assign mem_mode = mem_mode_t'(cfg[CFG_MEM_MODE][0]);
   assign wr_sel = src_sel_t'(cfg[CFG_WR_SEL][1:0]);

   // memory word in the upper half, alu word in the lower half
   assign prev_mem = flow_in[2*DATA_W-1 -: DATA_W];
   assign prev_alu = flow_in[DATA_W-1:0];
   assign flow_out = {own_mem, own_alu};

   assign wr_word = pick_src(wr_sel, own_mem, own_alu, prev_mem, prev_alu);

   // host is locked out while the stage runs
   assign host_en = data_valid && done;

   stage_agu #(
      .MEM_ADDR_W(MEM_ADDR_W)
   ) u_agu (
      .clk     (clk),
      .rst     (rst),
      .run     (run),
      .start   (cfg[CFG_START][MEM_ADDR_W-1:0]),
      .count   (cfg[CFG_COUNT]),
      .delay   (cfg[CFG_DELAY]),
      .agu_addr(agu_addr),
      .agu_en  (agu_en),
      .done    (done)
   );

   stage_mem #(
      .MEM_ADDR_W(MEM_ADDR_W)
   ) u_mem (
      .clk       (clk),
      .host_en   (host_en),
      .host_we   (data_we),
      .host_addr (data_addr),
      .host_wdata(data_data_in),
      .agu_en    (agu_en),
      .mode      (mem_mode),
      .agu_addr  (agu_addr),
      .agu_wdata (wr_word),
      .host_rdata(data_data_out),
      .flow_rdata(own_mem)
   );

   stage_alu u_alu (
      .clk     (clk),
      .rst     (rst),
      .op      (alu_op),
      .sel_a   (sel_a),
      .sel_b   (sel_b),
      .own_mem (own_mem),
      .own_alu (own_alu),
      .prev_mem(prev_mem),
      .prev_alu(prev_alu),
      .result  (own_alu)
   );

endmodule

// ==== source/versat_top.sv ====
module versat_top import versat_pkg::*; #(
   parameter int N_STAGE = 3,
   parameter int STAGE_W = 2,
   parameter int MEM_ADDR_W = 4
) (
   input  logic                          clk,
   input  logic                          rst,

   // control port
   input  logic                          ctr_valid,
   input  logic [STAGE_W+CFG_ADDR_W-1:0] ctr_addr,
   input  logic                          ctr_we,
   input  logic [DATA_W-1:0]             ctr_data_in,
   output logic [DATA_W-1:0]             ctr_data_out,

   // data port
   input  logic                          data_valid,
   input  logic [STAGE_W+MEM_ADDR_W-1:0] data_addr,
   input  logic                          data_we,
   input  logic [DATA_W-1:0]             data_data_in,
   output logic [DATA_W-1:0]             data_data_out
);

   logic [STAGE_W-1:0] ctr_stage;
   logic [STAGE_W-1:0] data_stage;
   logic [STAGE_W-1:0] data_sel_q;
   logic [N_STAGE-1:0] stage_ctr_valid;
   logic [N_STAGE-1:0] stage_data_valid;
   logic [N_STAGE-1:0] done_vec;
   logic               global_sel;
   logic               run;

   logic [DATA_W-1:0]   stage_ctr_rdata [N_STAGE];
   logic [DATA_W-1:0]   stage_data_rdata [N_STAGE];
   logic [2*DATA_W-1:0] flow_bus [N_STAGE];

   assign ctr_stage = ctr_addr[STAGE_W+CFG_ADDR_W-1 -: STAGE_W];
   assign data_stage = data_addr[STAGE_W+MEM_ADDR_W-1 -: STAGE_W];

   // the code right after the last stage is the global register
   assign global_sel = ctr_valid && (ctr_stage == STAGE_W'(N_STAGE));
   assign run = global_sel && ctr_we;

   // one-hot stage strobes
   always_comb begin
      stage_ctr_valid = '0;
      stage_data_valid = '0;
      for (int j = 0; j < N_STAGE; j++) begin
         if (ctr_stage == STAGE_W'(j))
            stage_ctr_valid[j] = ctr_valid;
         if (data_stage == STAGE_W'(j))
            stage_data_valid[j] = data_valid;
      end
   end

   // control reads are combinational
   always_comb begin
      ctr_data_out = '0;
      if (global_sel)
         ctr_data_out = DATA_W'(done_vec);
      for (int j = 0; j < N_STAGE; j++) begin
         if (stage_ctr_valid[j])
            ctr_data_out = stage_ctr_rdata[j];
      end
   end

   // data reads come back a cycle later, so keep the stage for the mux
   always_ff @(posedge clk) begin
      if (rst)
         data_sel_q <= STAGE_W'(N_STAGE);
      else if (data_valid && !data_we)
         data_sel_q <= data_stage;
   end

   always_comb begin
      data_data_out = '0;
      for (int j = 0; j < N_STAGE; j++) begin
         if (data_sel_q == STAGE_W'(j))
            data_data_out = stage_data_rdata[j];
      end
   end

   for (genvar i = 0; i < N_STAGE; i++) begin : g_stage
      // ring: stage 0 listens to the last stage
      localparam int PREV = (i + N_STAGE - 1) % N_STAGE;

      versat_stage #(
         .MEM_ADDR_W(MEM_ADDR_W)
      ) u_stage (
         .clk          (clk),
         .rst          (rst),
         .run          (run),
         .ctr_valid    (stage_ctr_valid[i]),
         .ctr_we       (ctr_we),
         .ctr_addr     (ctr_addr[CFG_ADDR_W-1:0]),
         .ctr_data_in  (ctr_data_in),
         .ctr_data_out (stage_ctr_rdata[i]),
         .data_valid   (stage_data_valid[i]),
         .data_we      (data_we),
         .data_addr    (data_addr[MEM_ADDR_W-1:0]),
         .data_data_in (data_data_in),
         .data_data_out(stage_data_rdata[i]),
         .flow_in      (flow_bus[PREV]),
         .flow_out     (flow_bus[i]),
         .done         (done_vec[i])
      );
   end

endmodule

// ==== verif/versat_sva.sv ====
module versat_sva import versat_pkg::*; #(
   parameter int N_STAGE = 3,
   parameter int MEM_ADDR_W = 4
) (
   input logic                           clk,
   input logic                           rst,
   input logic                           run,
   input logic [N_STAGE-1:0]             stage_ctr_valid,
   input logic [N_STAGE-1:0]             stage_data_valid,
   input logic [N_STAGE-1:0]             done_vec,
   input logic [N_STAGE-1:0]             agu_en,
   input logic [N_STAGE*MEM_ADDR_W-1:0]  agu_addr,
   input logic [N_STAGE*MEM_ADDR_W-1:0]  agu_start,
   input logic [N_STAGE*DATA_W-1:0]      agu_count
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam int DEPTH = 2**MEM_ADDR_W;

   a_ctr_onehot: assert property (@(posedge clk) disable iff (rst)
      $onehot0(stage_ctr_valid))
      else $error("control port selected more than one stage");

   a_data_onehot: assert property (@(posedge clk) disable iff (rst)
      $onehot0(stage_data_valid))
      else $error("data port selected more than one stage");

   a_done_drop: assert property (@(posedge clk) disable iff (rst)
      run |=> (done_vec == '0))
      else $error("done still high the cycle after a run pulse");

   for (genvar i = 0; i < N_STAGE; i++) begin : g_agu
      logic [MEM_ADDR_W-1:0] offset;
      logic [DATA_W-1:0]     count;

      // distance from start, modulo the depth
      assign offset = agu_addr[i*MEM_ADDR_W +: MEM_ADDR_W] - agu_start[i*MEM_ADDR_W +: MEM_ADDR_W];
      assign count = agu_count[i*DATA_W +: DATA_W];

      a_addr_range: assert property (@(posedge clk) disable iff (rst)
         agu_en[i] |-> (count >= DEPTH) || (DATA_W'(offset) < count))
         else $error("stage %0d address generator left its range", i);
   end

endmodule

// three stages in this build
bind versat_top versat_sva #(
   .N_STAGE   (N_STAGE),
   .MEM_ADDR_W(MEM_ADDR_W)
) u_sva (
   .clk             (clk),
   .rst             (rst),
   .run             (run),
   .stage_ctr_valid (stage_ctr_valid),
   .stage_data_valid(stage_data_valid),
   .done_vec        (done_vec),
   .agu_en          ({g_stage[2].u_stage.agu_en,
                      g_stage[1].u_stage.agu_en,
                      g_stage[0].u_stage.agu_en}),
   .agu_addr        ({g_stage[2].u_stage.agu_addr,
                      g_stage[1].u_stage.agu_addr,
                      g_stage[0].u_stage.agu_addr}),
   .agu_start       ({g_stage[2].u_stage.u_agu.start,
                      g_stage[1].u_stage.u_agu.start,
                      g_stage[0].u_stage.u_agu.start}),
   .agu_count       ({g_stage[2].u_stage.u_agu.count,
                      g_stage[1].u_stage.u_agu.count,
                      g_stage[0].u_stage.u_agu.count})
);

// ==== verif/versat_tb.sv ====
module versat_tb import versat_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_STAGE = 3;
   localparam int STAGE_W = 2;
   localparam int MEM_ADDR_W = 4;
   localparam int DEPTH = 2**MEM_ADDR_W;
   localparam int LEN = 4;
   localparam int RUN_LIMIT = 200;
   // the tests take roughly 700 cycles
   localparam int CYCLE_LIMIT = 3000;

   // configuration register indices
   localparam int REG_ALU_OP = 0;
   localparam int REG_SEL_A = 1;
   localparam int REG_SEL_B = 2;
   localparam int REG_MEM_MODE = 3;
   localparam int REG_WR_SEL = 4;
   localparam int REG_START = 5;
   localparam int REG_COUNT = 6;
   localparam int REG_DELAY = 7;

   logic                          clk;
   logic                          rst;
   logic                          ctr_valid;
   logic [STAGE_W+CFG_ADDR_W-1:0] ctr_addr;
   logic                          ctr_we;
   logic [DATA_W-1:0]             ctr_data_in;
   logic [DATA_W-1:0]             ctr_data_out;
   logic                          data_valid;
   logic [STAGE_W+MEM_ADDR_W-1:0] data_addr;
   logic                          data_we;
   logic [DATA_W-1:0]             data_data_in;
   logic [DATA_W-1:0]             data_data_out;

   int     errors = 0;
   int     checks = 0;
   int     cycles = 0;
   integer seed = 16;

   versat_top #(
      .N_STAGE   (N_STAGE),
      .STAGE_W   (STAGE_W),
      .MEM_ADDR_W(MEM_ADDR_W)
   ) u_dut (
      .clk          (clk),
      .rst          (rst),
      .ctr_valid    (ctr_valid),
      .ctr_addr     (ctr_addr),
      .ctr_we       (ctr_we),
      .ctr_data_in  (ctr_data_in),
      .ctr_data_out (ctr_data_out),
      .data_valid   (data_valid),
      .data_addr    (data_addr),
      .data_we      (data_we),
      .data_data_in (data_data_in),
      .data_data_out(data_data_out)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
         $display("Done: errors found");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      end
   endtask

   // all host tasks start and end 1 ns after a rising edge
   task automatic host_write_cfg(input int stage, input int idx, input logic [DATA_W-1:0] value);
      ctr_valid = 1'b1;
      ctr_we = 1'b1;
      ctr_addr = {stage[STAGE_W-1:0], idx[CFG_ADDR_W-1:0]};
      ctr_data_in = value;
      @(posedge clk);
      #1;
      ctr_valid = 1'b0;
      ctr_we = 1'b0;
   endtask

   task automatic host_read_cfg(input int stage, input int idx, output logic [DATA_W-1:0] value);
      ctr_valid = 1'b1;
      ctr_we = 1'b0;
      ctr_addr = {stage[STAGE_W-1:0], idx[CFG_ADDR_W-1:0]};
      // combinational read, sampled mid cycle
      #3;
      value = ctr_data_out;
      @(posedge clk);
      #1;
      ctr_valid = 1'b0;
   endtask

   task automatic host_write_mem(input int stage, input int addr, input logic [DATA_W-1:0] value);
      data_valid = 1'b1;
      data_we = 1'b1;
      data_addr = {stage[STAGE_W-1:0], addr[MEM_ADDR_W-1:0]};
      data_data_in = value;
      @(posedge clk);
      #1;
      data_valid = 1'b0;
      data_we = 1'b0;
   endtask

   task automatic host_read_mem(input int stage, input int addr, output logic [DATA_W-1:0] value);
      data_valid = 1'b1;
      data_we = 1'b0;
      data_addr = {stage[STAGE_W-1:0], addr[MEM_ADDR_W-1:0]};
      @(posedge clk);
      #1;
      data_valid = 1'b0;
      value = data_data_out;
   endtask

   task automatic setup_stage(input int stage, input int op, input int sel_a, input int sel_b,
                              input int mode, input int wr_sel, input int start,
                              input int count, input int delay);
      host_write_cfg(stage, REG_ALU_OP, op);
      host_write_cfg(stage, REG_SEL_A, sel_a);
      host_write_cfg(stage, REG_SEL_B, sel_b);
      host_write_cfg(stage, REG_MEM_MODE, mode);
      host_write_cfg(stage, REG_WR_SEL, wr_sel);
      host_write_cfg(stage, REG_START, start);
      host_write_cfg(stage, REG_COUNT, count);
      host_write_cfg(stage, REG_DELAY, delay);
   endtask

   task automatic run_and_wait();
      logic [DATA_W-1:0] status;
      int waited;
      waited = 0;
      host_write_cfg(N_STAGE, 0, '0);
      host_read_cfg(N_STAGE, 0, status);
      while (status[N_STAGE-1:0] != {N_STAGE{1'b1}} && waited < RUN_LIMIT) begin
         waited++;
         host_read_cfg(N_STAGE, 0, status);
      end
      if (status[N_STAGE-1:0] != {N_STAGE{1'b1}}) begin
         errors++;
         $display("stages did not finish within %0d cycles of the run write", RUN_LIMIT);
      end
   endtask

   function automatic logic [DATA_W-1:0] expected_alu(input int op, input logic [DATA_W-1:0] a,
                                                       input logic [DATA_W-1:0] b);
      case (op)
         0: return a + b;
         1: return a - b;
         2: return a & b;
         3: return a | b;
         4: return a ^ b;
         default: return a;
      endcase
   endfunction

   task automatic report_test(input string name, input int err_before);
      if (errors == err_before)
         $display("%s: ok", name);
      else
         $display("%s: %0d errors", name, errors - err_before);
   endtask

   task automatic test_reset_state();
      logic [DATA_W-1:0] value;
      int err_before;
      err_before = errors;
      host_read_cfg(N_STAGE, 0, value);
      check_value("done bits", DATA_W'((1 << N_STAGE) - 1), value);
      for (int s = 0; s < N_STAGE; s++) begin
         for (int r = 0; r < 8; r++) begin
            host_read_cfg(s, r, value);
            check_value($sformatf("stage%0d cfg%0d", s, r), '0, value);
         end
      end
      report_test("reset state", err_before);
   endtask

   task automatic test_host_access();
      logic [DATA_W-1:0] cfg_exp [N_STAGE][8];
      logic [DATA_W-1:0] mem_exp [N_STAGE][DEPTH];
      logic [DATA_W-1:0] value;
      int err_before;
      err_before = errors;
      for (int s = 0; s < N_STAGE; s++) begin
         for (int r = 0; r < 8; r++) begin
            cfg_exp[s][r] = $random(seed);
            host_write_cfg(s, r, cfg_exp[s][r]);
         end
         for (int a = 0; a < DEPTH; a++) begin
            mem_exp[s][a] = $random(seed);
            host_write_mem(s, a, mem_exp[s][a]);
         end
      end
      for (int s = 0; s < N_STAGE; s++) begin
         for (int r = 0; r < 8; r++) begin
            host_read_cfg(s, r, value);
            check_value($sformatf("stage%0d cfg%0d", s, r), cfg_exp[s][r], value);
         end
         for (int a = 0; a < DEPTH; a++) begin
            host_read_mem(s, a, value);
            check_value($sformatf("stage%0d mem%0d", s, a), mem_exp[s][a], value);
         end
      end
      // no stage behind this code on the data port
      host_read_mem(N_STAGE, 5, value);
      check_value("unmapped data read", '0, value);
      report_test("host access", err_before);
   endtask

   task automatic test_pipeline();
      logic [DATA_W-1:0] a [LEN];
      logic [DATA_W-1:0] b [LEN];
      logic [DATA_W-1:0] value;
      int err_before;
      err_before = errors;
      for (int op = 0; op < 6; op++) begin
         for (int k = 0; k < LEN; k++) begin
            a[k] = $random(seed);
            b[k] = $random(seed);
            host_write_mem(0, k, a[k]);
            host_write_mem(1, k, b[k]);
            host_write_mem(2, k, ~expected_alu(op, a[k], b[k]));
         end
         setup_stage(0, ALU_ADD, SRC_OWN_MEM, SRC_OWN_MEM, MEM_READ, SRC_OWN_MEM, 0, LEN, 0);
         setup_stage(1, op, SRC_PREV_MEM, SRC_OWN_MEM, MEM_READ, SRC_OWN_MEM, 0, LEN, 0);
         // one cycle for the memory, one for the alu
         setup_stage(2, ALU_ADD, SRC_OWN_MEM, SRC_OWN_MEM, MEM_WRITE, SRC_PREV_ALU, 0, LEN, 2);
         run_and_wait();
         for (int k = 0; k < LEN; k++) begin
            host_read_mem(2, k, value);
            check_value($sformatf("stage2 mem%0d op%0d", k, op),
                        expected_alu(op, a[k], b[k]), value);
         end
      end
      report_test("pipeline", err_before);
   endtask

   task automatic test_ring_wrap();
      logic [DATA_W-1:0] d [LEN];
      logic [DATA_W-1:0] value;
      int err_before;
      err_before = errors;
      for (int k = 0; k < LEN; k++) begin
         d[k] = $random(seed);
         host_write_mem(2, k, d[k]);
         host_write_mem(1, k, ~d[k]);
      end
      setup_stage(2, ALU_ADD, SRC_OWN_MEM, SRC_OWN_MEM, MEM_READ, SRC_OWN_MEM, 0, LEN, 0);
      setup_stage(0, ALU_PASS_A, SRC_PREV_MEM, SRC_PREV_MEM, MEM_READ, SRC_OWN_MEM, 0, 0, 0);
      setup_stage(1, ALU_ADD, SRC_OWN_MEM, SRC_OWN_MEM, MEM_WRITE, SRC_PREV_ALU, 0, LEN, 2);
      run_and_wait();
      for (int k = 0; k < LEN; k++) begin
         host_read_mem(1, k, value);
         check_value($sformatf("stage1 mem%0d", k), d[k], value);
      end
      report_test("ring wrap", err_before);
   endtask

   task automatic test_addr_wrap();
      logic [DATA_W-1:0] d [LEN];
      logic [DATA_W-1:0] exp_mem [DEPTH];
      logic [DATA_W-1:0] value;
      int err_before;
      int first;
      err_before = errors;
      first = DEPTH - 2;
      for (int a = 0; a < DEPTH; a++) begin
         exp_mem[a] = $random(seed);
         host_write_mem(0, a, exp_mem[a]);
      end
      for (int k = 0; k < LEN; k++) begin
         d[k] = $random(seed);
         host_write_mem(2, k, d[k]);
         exp_mem[(first + k) % DEPTH] = d[k];
      end
      setup_stage(2, ALU_ADD, SRC_OWN_MEM, SRC_OWN_MEM, MEM_READ, SRC_OWN_MEM, 0, LEN, 0);
      setup_stage(1, ALU_ADD, SRC_OWN_MEM, SRC_OWN_MEM, MEM_READ, SRC_OWN_MEM, 0, 0, 0);
      // writer lags the reader by the memory cycle only
      setup_stage(0, ALU_ADD, SRC_OWN_MEM, SRC_OWN_MEM, MEM_WRITE, SRC_PREV_MEM, first, LEN, 1);
      run_and_wait();
      for (int a = 0; a < DEPTH; a++) begin
         host_read_mem(0, a, value);
         check_value($sformatf("stage0 mem%0d", a), exp_mem[a], value);
      end
      report_test("address wrap", err_before);
   endtask

   initial begin
      rst = 1'b1;
      ctr_valid = 1'b0;
      ctr_addr = '0;
      ctr_we = 1'b0;
      ctr_data_in = '0;
      data_valid = 1'b0;
      data_addr = '0;
      data_we = 1'b0;
      data_data_in = '0;
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;
      test_reset_state();
      test_host_access();
      test_pipeline();
      test_ring_wrap();
      test_addr_wrap();
      $display("checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycles);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

// ==== files.f ====
source/versat_pkg.sv
source/stage_agu.sv
source/stage_mem.sv
source/stage_alu.sv
source/versat_stage.sv
source/versat_top.sv
verif/versat_sva.sv
verif/versat_tb.sv

// ==== Bender.yml ====
package:
  name: versat

sources:
  - source/versat_pkg.sv
  - source/stage_agu.sv
  - source/stage_mem.sv
  - source/stage_alu.sv
  - source/versat_stage.sv
  - source/versat_top.sv
  - target: test
    files:
      - verif/versat_sva.sv
      - verif/versat_tb.sv
